// File: flist.f
+incdir+include
verilog/sram_pkg.sv
verilog/byte_lane_sram.sv
verilog/line_read_sequencer.sv
verilog/tile_pingpong_buffer.sv
verilog/sram_subsystem.sv
testbench/sram_subsystem_asserts.sv
testbench/sram_subsystem_tb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = sram_subsystem_tb
FLIST      = flist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Finished with no errors
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/sram_subsystem_tb.sv
`timescale 1ns/10ps
`include "sram_cfg.svh"

module sram_subsystem_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_OPS     = 21;
    localparam int WATCHDOG_NS = 2 * (NUM_OPS * 10 * CLK_PERIOD + 3 * CLK_PERIOD);

    typedef enum logic [2:0] {
        OP_IDLE, OP_TWR, OP_KWR, OP_SWAP, OP_TRD, OP_KRD, OP_BOTH, OP_BUSY
    } op_e;

    // line2 is the kernel line of a concurrent read
    typedef struct packed {
        op_e        op;
        logic [6:0] line;
        logic [6:0] line2;
        logic [3:0] mask;
    } op_t;

    logic               clk;
    logic               rst_n;
    sram_pkg::byte_wr_t tile_wr;
    logic               tile_swap;
    logic               tile_rd_en;
    logic [6:0]         tile_rd_line_addr;
    sram_pkg::line_rd_t tile_rd;
    sram_pkg::byte_wr_t kernel_wr;
    logic               kernel_rd_en;
    logic [5:0]         kernel_rd_line_addr;
    sram_pkg::line_rd_t kernel_rd;

    op_t         ops [NUM_OPS];
    logic [7:0]  tile_model [2][2048];
    logic [7:0]  kernel_model [1024];
    logic        model_wr_bank;
    logic [31:0] lfsr;
    int          errors;
    int          checks;

    sram_subsystem uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================
    // Stimulus helpers
    // ========================================
    function automatic op_t entry(input op_e kind, input logic [6:0] line,
                                  input logic [6:0] line2, input logic [3:0] mask);
        return '{kind, line, line2, mask};
    endfunction

    // Taps 32, 22, 2, 1
    task automatic take_byte(output logic [7:0] b);
        logic fb;
        for (int i = 0; i < 8; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            b    = {b[6:0], fb};
        end
    endtask

    // One byte per cycle, lanes of each word picked by mask
    task automatic write_line(input bit to_kernel, input logic [6:0] line,
                              input logic [3:0] mask);
        logic [10:0] baddr;
        logic [7:0]  data;
        for (int w = 0; w < 4; w++) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mask[lane]) begin
                    baddr = {line, 2'(w), 2'(lane)};
                    take_byte(data);
                    if (to_kernel) begin
                        kernel_wr = '{en: 1'b1, addr: baddr, data: data};
                        kernel_model[baddr[9:0]] = data;
                    end else begin
                        tile_wr = '{en: 1'b1, addr: baddr, data: data};
                        tile_model[model_wr_bank][baddr] = data;
                    end
                    @(negedge clk);
                end
            end
        end
        tile_wr.en   = 1'b0;
        kernel_wr.en = 1'b0;
    endtask

    // Lowest byte address lands in the least significant byte
    function automatic logic [127:0] model_line(input bit from_kernel, input logic [6:0] line);
        logic [127:0] l;
        logic [10:0]  a;
        for (int j = 0; j < 16; j++) begin
            a = {line, 4'(j)};
            l[8*j +: 8] = from_kernel ? kernel_model[a[9:0]] : tile_model[~model_wr_bank][a];
        end
        return l;
    endfunction

    // ========================================
    // Line result checking
    // ========================================
    // Entered on the falling edge after the request edge
    task automatic collect_line(input bit is_kernel, input logic [6:0] line,
                                input int poke_cycle);
        string        name;
        logic [127:0] expected;
        logic [127:0] got;
        int           cycles;
        bit           seen;
        name     = is_kernel ? "kernel_rd" : "tile_rd";
        expected = model_line(is_kernel, line);
        cycles   = 0;
        seen     = 1'b0;
        while (!seen && cycles < 12) begin
            seen = is_kernel ? kernel_rd.valid : tile_rd.valid;
            if (!seen) begin
                @(posedge clk);
                cycles++;
                @(negedge clk);
                // Stray request for another line while the sequencer is busy
                if (poke_cycle >= 0) begin
                    tile_rd_en        = (cycles == poke_cycle);
                    tile_rd_line_addr = ~line;
                end
            end
        end
        if (poke_cycle >= 0) tile_rd_en = 1'b0;
        checks++;
        assert (seen) else begin
            $display("%s: no valid pulse within %0d cycles of the request", name, cycles);
            errors++;
        end
        if (seen) begin
            got    = is_kernel ? kernel_rd.data : tile_rd.data;
            checks += 2;
            assert (cycles == 5) else begin
                $display("** Error: %s.valid latency expected %h got %h", name, 5, cycles);
                errors++;
            end
            assert (got === expected) else begin
                $display("** Error: %s.data expected %h got %h", name, expected, got);
                errors++;
            end
            repeat (5) begin
                @(negedge clk);
                checks++;
                assert (!(is_kernel ? kernel_rd.valid : tile_rd.valid)) else begin
                    $display("%s: a second valid pulse followed the line", name);
                    errors++;
                end
            end
        end
    endtask

    // ========================================
    // Operation table and main sequence
    // ========================================
    initial begin
        op_t cur;
        int  err_before;
        tile_wr             = '0;
        kernel_wr           = '0;
        tile_swap           = 1'b0;
        tile_rd_en          = 1'b0;
        tile_rd_line_addr   = '0;
        kernel_rd_en        = 1'b0;
        kernel_rd_line_addr = '0;
        rst_n               = 1'b0;
        lfsr                = 32'h86d1;
        model_wr_bank       = 1'b0;
        errors              = 0;
        checks              = 0;

        ops[0]  = entry(OP_IDLE, 7'd8,   7'd0,  4'h0);
        ops[1]  = entry(OP_TWR,  7'd3,   7'd0,  4'hf);
        ops[2]  = entry(OP_TWR,  7'd9,   7'd0,  4'hf);
        ops[3]  = entry(OP_SWAP, 7'd0,   7'd0,  4'h0);
        ops[4]  = entry(OP_TRD,  7'd3,   7'd0,  4'h0);
        ops[5]  = entry(OP_TWR,  7'd3,   7'd0,  4'hf);
        ops[6]  = entry(OP_TRD,  7'd3,   7'd0,  4'h0);
        ops[7]  = entry(OP_SWAP, 7'd0,   7'd0,  4'h0);
        ops[8]  = entry(OP_TRD,  7'd3,   7'd0,  4'h0);
        ops[9]  = entry(OP_TWR,  7'd3,   7'd0,  4'h5);
        ops[10] = entry(OP_TWR,  7'd127, 7'd0,  4'hf);
        ops[11] = entry(OP_SWAP, 7'd0,   7'd0,  4'h0);
        ops[12] = entry(OP_TRD,  7'd3,   7'd0,  4'h0);
        ops[13] = entry(OP_TRD,  7'd127, 7'd0,  4'h0);
        ops[14] = entry(OP_KWR,  7'd2,   7'd0,  4'hf);
        ops[15] = entry(OP_KWR,  7'd63,  7'd0,  4'hf);
        ops[16] = entry(OP_KRD,  7'd2,   7'd0,  4'h0);
        // Byte address bit 10 set, lands on kernel line 2
        ops[17] = entry(OP_KWR,  7'd66,  7'd0,  4'ha);
        ops[18] = entry(OP_KRD,  7'd2,   7'd0,  4'h0);
        ops[19] = entry(OP_BOTH, 7'd9,   7'd63, 4'h0);
        ops[20] = entry(OP_BUSY, 7'd127, 7'd0,  4'h0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_OPS; i++) begin
            cur        = ops[i];
            err_before = errors;
            case (cur.op)
                OP_IDLE: begin
                    repeat (cur.line) begin
                        @(negedge clk);
                        checks++;
                        assert (!tile_rd.valid && !kernel_rd.valid) else begin
                            $display("A line valid pulse appeared with no read requested");
                            errors++;
                        end
                    end
                end
                OP_TWR:  write_line(1'b0, cur.line, cur.mask);
                OP_KWR:  write_line(1'b1, cur.line, cur.mask);
                OP_SWAP: begin
                    tile_swap = 1'b1;
                    @(negedge clk);
                    tile_swap     = 1'b0;
                    model_wr_bank = ~model_wr_bank;
                end
                OP_KRD: begin
                    kernel_rd_en        = 1'b1;
                    kernel_rd_line_addr = cur.line[5:0];
                    @(negedge clk);
                    kernel_rd_en = 1'b0;
                    collect_line(1'b1, cur.line, -1);
                end
                OP_BOTH: begin
                    tile_rd_en          = 1'b1;
                    tile_rd_line_addr   = cur.line;
                    kernel_rd_en        = 1'b1;
                    kernel_rd_line_addr = cur.line2[5:0];
                    @(negedge clk);
                    tile_rd_en   = 1'b0;
                    kernel_rd_en = 1'b0;
                    fork
                        collect_line(1'b0, cur.line, -1);
                        collect_line(1'b1, cur.line2, -1);
                    join
                end
                default: begin
                    tile_rd_en        = 1'b1;
                    tile_rd_line_addr = cur.line;
                    @(negedge clk);
                    tile_rd_en = 1'b0;
                    collect_line(1'b0, cur.line, (cur.op == OP_BUSY) ? 2 : -1);
                end
            endcase
            $display("Test %0d %s line %0d: %s", i, cur.op.name(), cur.line,
                     (errors == err_before) ? "ok" : "FAILED");
        end

        $display("Tests: %0d  checks: %0d  errors: %0d", NUM_OPS, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Hang guard sized from the table length
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the operation table completed",
                 WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: testbench/sram_subsystem_asserts.sv
`timescale 1ns/10ps

module sram_subsystem_asserts (
    input logic clk,
    input logic rst_n,
    input logic accept,
    input logic word_rd_en,
    input logic valid
);

    // ========================================
    // Line read sequencer timing
    // ========================================
    // A line result is a single-cycle pulse
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        valid |=> !valid)
        else $error("line valid held high for more than one cycle");

    // Four word reads back to back followed by a gap
    a_word_burst: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> word_rd_en ##1 word_rd_en ##1 word_rd_en ##1 word_rd_en ##1 !word_rd_en)
        else $error("word read enable not high for exactly four cycles after accept");

    // Valid is set by the fifth edge after the accept edge and seen on the sixth
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> ##1 (!valid) [*4] ##1 valid)
        else $error("line valid did not rise five edges after accept");

endmodule

bind line_read_sequencer sram_subsystem_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept     (accept),
    .word_rd_en (word_rd_en),
    .valid      (line.valid)
);

// File: verilog/sram_subsystem.sv
`timescale 1ns/10ps
`include "sram_cfg.svh"

module sram_subsystem (
    input  logic               clk,
    input  logic               rst_n,

    // Input tile buffer
    input  sram_pkg::byte_wr_t tile_wr,
    input  logic               tile_swap,
    input  logic               tile_rd_en,
    input  logic [6:0]         tile_rd_line_addr,
    output sram_pkg::line_rd_t tile_rd,

    // Kernel weight memory
    input  sram_pkg::byte_wr_t kernel_wr,
    input  logic               kernel_rd_en,
    input  logic [5:0]         kernel_rd_line_addr,
    output sram_pkg::line_rd_t kernel_rd
);

    localparam int KERNEL_WORD_AW = $clog2(`KERNEL_WORDS);

    logic                      kernel_word_rd_en;
    logic [KERNEL_WORD_AW-1:0] kernel_word_addr;
    logic [`SRAM_WORD_W-1:0]   kernel_word_data;

    // ========================================
    // Input tile ping-pong buffer
    // ========================================
    tile_pingpong_buffer u_tile (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr           (tile_wr),
        .swap         (tile_swap),
        .rd_en        (tile_rd_en),
        .rd_line_addr (tile_rd_line_addr),
        .rd           (tile_rd)
    );

    // ========================================
    // Kernel memory and its line reader
    // ========================================
    byte_lane_sram #(
        .WORDS (`KERNEL_WORDS)
    ) u_kernel_mem (
        .clk     (clk),
        .wr      (kernel_wr),
        .rd_en   (kernel_word_rd_en),
        .rd_addr (kernel_word_addr),
        .rd_data (kernel_word_data)
    );

    line_read_sequencer #(
        .LINE_ADDR_W (KERNEL_WORD_AW - 2)
    ) u_kernel_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (kernel_rd_en),
        .line_addr  (kernel_rd_line_addr),
        .word_rd_en (kernel_word_rd_en),
        .word_addr  (kernel_word_addr),
        .word_data  (kernel_word_data),
        .line       (kernel_rd)
    );

endmodule

// File: verilog/tile_pingpong_buffer.sv
`timescale 1ns/10ps
`include "sram_cfg.svh"

module tile_pingpong_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  sram_pkg::byte_wr_t wr,
    input  logic               swap,
    input  logic               rd_en,
    input  logic [6:0]         rd_line_addr,
    output sram_pkg::line_rd_t rd
);

    localparam int WORD_AW = $clog2(`TILE_BANK_WORDS);
    localparam int LINE_AW = WORD_AW - 2;

    // Bank currently taking loader writes, reads use the other one
    logic wr_bank;
    logic rd_bank;

    sram_pkg::byte_wr_t      bank_wr      [2];
    logic                    bank_rd_en   [2];
    logic [`SRAM_WORD_W-1:0] bank_rd_data [2];

    logic                    word_rd_en;
    logic [WORD_AW-1:0]      word_addr;
    logic [`SRAM_WORD_W-1:0] word_data;

    // ========================================
    // Ping-pong state
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bank <= 1'b0;
        end else if (swap) begin
            wr_bank <= ~wr_bank;
        end
    end

    assign rd_bank = ~wr_bank;

    // ========================================
    // Bank pair
    // ========================================
    for (genvar b = 0; b < 2; b++) begin : g_bank
        // Only the write bank sees the strobe
        assign bank_wr[b] = '{
            en:   wr.en && (wr_bank == 1'(b)),
            addr: wr.addr,
            data: wr.data
        };

        assign bank_rd_en[b] = word_rd_en && (rd_bank == 1'(b));

        byte_lane_sram #(
            .WORDS (`TILE_BANK_WORDS)
        ) u_bank (
            .clk     (clk),
            .wr      (bank_wr[b]),
            .rd_en   (bank_rd_en[b]),
            .rd_addr (word_addr),
            .rd_data (bank_rd_data[b])
        );
    end

    // Bank state is stable across a line read, so no delayed select
    assign word_data = rd_bank ? bank_rd_data[1] : bank_rd_data[0];

    // ========================================
    // Line read sequencer
    // ========================================
    line_read_sequencer #(
        .LINE_ADDR_W (LINE_AW)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (rd_en),
        .line_addr  (rd_line_addr),
        .word_rd_en (word_rd_en),
        .word_addr  (word_addr),
        .word_data  (word_data),
        .line       (rd)
    );

endmodule

// File: verilog/line_read_sequencer.sv
`timescale 1ns/10ps
`include "sram_cfg.svh"

module line_read_sequencer #(
    parameter int LINE_ADDR_W = 7
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rd_en,
    input  logic [LINE_ADDR_W-1:0]    line_addr,
    output logic                      word_rd_en,
    output logic [LINE_ADDR_W+1:0]    word_addr,
    input  logic [`SRAM_WORD_W-1:0]   word_data,
    output sram_pkg::line_rd_t        line
);

    logic                    busy;
    logic [2:0]              step;
    logic [LINE_ADDR_W-1:0]  line_q;
    logic [`SRAM_WORD_W-1:0] hold [3];
    logic                    last;
    logic                    accept;

    // ========================================
    // Step control
    // ========================================
    // step counts edges since accept: 0..3 issue words, 4 is the final collect
    assign last   = busy && (step == 3'(`LINE_WORDS));
    assign accept = rd_en && (!busy || last);

    assign word_rd_en = busy && (step < 3'(`LINE_WORDS));
    assign word_addr  = {line_q, step[1:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            step   <= '0;
            line_q <= '0;
        end else if (accept) begin
            // A new line may start on the same edge the previous one finishes
            busy   <= 1'b1;
            step   <= '0;
            line_q <= line_addr;
        end else if (last) begin
            busy <= 1'b0;
        end else if (busy) begin
            step <= step + 3'd1;
        end
    end

    // ========================================
    // Word collection
    // ========================================
    // Memory data for word k shows up two edges after its step
    always_ff @(posedge clk) begin
        if (busy) begin
            case (step)
                3'd1:    hold[0] <= word_data;
                3'd2:    hold[1] <= word_data;
                3'd3:    hold[2] <= word_data;
                default: ;
            endcase
        end
    end

    // Word 3 goes straight from the memory into the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line.valid <= 1'b0;
            line.data  <= '0;
        end else begin
            line.valid <= last;
            if (last) begin
                line.data <= {word_data, hold[2], hold[1], hold[0]};
            end
        end
    end

endmodule

// File: verilog/byte_lane_sram.sv
`timescale 1ns/10ps
`include "sram_cfg.svh"

module byte_lane_sram #(
    parameter int WORDS = 512
) (
    input  logic                         clk,
    input  sram_pkg::byte_wr_t           wr,
    input  logic                         rd_en,
    input  logic [$clog2(WORDS)-1:0]     rd_addr,
    output logic [`SRAM_WORD_W-1:0]      rd_data
);

    localparam int AW = $clog2(WORDS);

    logic [`SRAM_WORD_W-1:0]         mem [WORDS];
    logic [AW-1:0]                   wr_word;
    logic [`SRAM_BYTES_PER_WORD-1:0] lane_mask;
    logic [`SRAM_WORD_W-1:0]         wr_din;

    // ========================================
    // Byte write decode
    // ========================================
    // Upper address bits beyond the array depth are dropped and so alias
    assign wr_word   = wr.addr[AW+1:2];
    assign lane_mask = `SRAM_BYTES_PER_WORD'(1) << wr.addr[1:0];

    // Same byte on every lane, the mask picks the one that lands
    assign wr_din = {`SRAM_BYTES_PER_WORD{wr.data}};

    always_ff @(posedge clk) begin
        if (wr.en) begin
            for (int i = 0; i < `SRAM_BYTES_PER_WORD; i++) begin
                if (lane_mask[i]) begin
                    mem[wr_word][8*i +: 8] <= wr_din[8*i +: 8];
                end
            end
        end
    end

    // ========================================
    // Registered word read
    // ========================================
    // One cycle latency, output holds when no read is issued
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: verilog/sram_pkg.sv
`include "sram_cfg.svh"

package sram_pkg;

    // ========================================
    // Loader side byte write
    // ========================================
    // addr[1:0] picks the lane, upper bits pick the word
    typedef struct packed {
        logic                    en;
        logic [`BYTE_ADDR_W-1:0] addr;
        logic [7:0]              data;
    } byte_wr_t;

    // ========================================
    // Compute side line result
    // ========================================
    // Word k of the line lives at data[32k +: 32], lowest address first
    typedef struct packed {
        logic               valid;
        logic [`LINE_W-1:0] data;
    } line_rd_t;

endpackage

// File: include/sram_cfg.svh
`ifndef SRAM_CFG_SVH
`define SRAM_CFG_SVH

// ========================================
// Memory word and line geometry
// ========================================
`define SRAM_WORD_W         32
`define SRAM_BYTES_PER_WORD 4
`define LINE_WORDS          4
`define LINE_W              128

// Byte address of the largest memory (one 2 KB tile bank)
`define BYTE_ADDR_W         11

// ========================================
// Memory depths in words
// ========================================
`define TILE_BANK_WORDS     512
`define KERNEL_WORDS        256

`endif
